//--- hdl/addrgen_pkg.sv
/* Shared widths, types and AXI limits of the vector address generator.
   Modules import it in their body and use scoped names in their ports. */
package addrgen_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths that carry a meaning
  //////////////////////////////////////////////////////////////////////

  // Physical byte address
  typedef logic [31:0] axi_addr_t;
  // Element count of one instruction
  typedef logic [15:0] vlen_t;
  // Byte distance between two strided elements
  typedef logic [31:0] stride_t;
  // AXI beats minus one
  typedef logic [7:0] axi_len_t;
  // Log2 of the bytes per beat
  typedef logic [2:0] axi_size_t;

  // Element width, the value is log2 of its byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  //////////////////////////////////////////////////////////////////////
  // AXI limits
  //////////////////////////////////////////////////////////////////////

  // Longest INCR burst in beats
  localparam int unsigned AxiMaxBurst = 256;
  // No burst may cross a 4 KiB page
  localparam int unsigned PageBits    = 12;
  // 8-byte data bus
  localparam int unsigned BusBytesLog = 3;

endpackage

//--- hdl/vmem_req_reg.sv
/* Accepts one vector memory instruction, rejects a misaligned base and holds
   the fields while the bursts are issued, then acknowledges the sequencer. */
`timescale 1ns/1ps

module vmem_req_reg (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Sequencer side, held until ack_o
  input  logic                   req_valid_i,
  input  logic                   req_is_load_i,
  input  logic                   req_unit_stride_i,
  input  addrgen_pkg::axi_addr_t req_addr_i,
  input  addrgen_pkg::vlen_t     req_len_i,
  input  addrgen_pkg::stride_t   req_stride_i,
  input  addrgen_pkg::vew_e      req_vew_i,
  // Held instruction toward the burst logic
  output logic                   start_o,
  output logic                   is_load_o,
  output logic                   unit_stride_o,
  output addrgen_pkg::axi_addr_t addr_o,
  output addrgen_pkg::vlen_t     len_o,
  output addrgen_pkg::stride_t   stride_o,
  output addrgen_pkg::vew_e      vew_o,
  input  logic                   done_i,
  output logic                   ack_o,
  output logic                   error_o
);

  import addrgen_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    BUSY
  } state_e;

  state_e state_q, state_d;
  logic   ack_q;
  logic   accept;
  logic   misaligned;

  // ack_q blocks a second accept while the sequencer still sees its valid
  assign accept = (state_q == IDLE) && req_valid_i && !ack_q;

  // Base must be aligned to the element width
  always_comb begin
    case (vew_o)
      EW16:    misaligned = addr_o[0];
      EW32:    misaligned = |addr_o[1:0];
      EW64:    misaligned = |addr_o[2:0];
      default: misaligned = 1'b0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    start_o = 1'b0;
    error_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = CHECK;
        end
      end
      CHECK: begin
        if (misaligned) begin
          error_o = 1'b1;
          state_d = IDLE;
        end else begin
          start_o = 1'b1;
          state_d = BUSY;
        end
      end
      BUSY: begin
        if (done_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // A rejection is acknowledged at once, a completion one cycle after done
  assign ack_o = ack_q | error_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= (state_q == BUSY) && done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      is_load_o     <= req_is_load_i;
      unit_stride_o <= req_unit_stride_i;
      addr_o        <= req_addr_i;
      len_o         <= req_len_i;
      stride_o      <= req_stride_i;
      vew_o         <= req_vew_i;
    end
  end

endmodule

//--- hdl/burst_planner.sv
/* Walks the address range of the held instruction and presents the address,
   length and size of the next AXI request; each step advances it. */
`timescale 1ns/1ps

module burst_planner (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  logic                    unit_stride_i,
  input  addrgen_pkg::axi_addr_t  addr_i,
  input  addrgen_pkg::vlen_t      len_i,
  input  addrgen_pkg::stride_t    stride_i,
  input  addrgen_pkg::vew_e       vew_i,
  input  logic                    step_i,
  output addrgen_pkg::axi_addr_t  cur_addr_o,
  output addrgen_pkg::axi_len_t   cur_len_o,
  output addrgen_pkg::axi_size_t  cur_size_o,
  output logic                    last_o
);

  import addrgen_pkg::*;

  // Remaining beats for unit-stride, remaining elements for strided
  localparam int unsigned CntW     = $bits(vlen_t) + 1;
  // Instruction bytes plus the base offset in the first bus word
  localparam int unsigned BytesW   = $bits(vlen_t) + BusBytesLog + 1;
  localparam int unsigned PageW    = PageBits + 1;
  localparam int unsigned BusBytes = 1 << BusBytesLog;

  typedef logic [CntW-1:0] cnt_t;

  axi_addr_t         cur_addr_q;
  cnt_t              cnt_q;
  logic [BytesW-1:0] total_bytes;
  cnt_t              total_beats;
  logic [PageW-1:0]  page_bytes;
  cnt_t              page_beats;
  cnt_t              beats;
  axi_addr_t         incr;

  //////////////////////////////////////////////////////////////////////
  // Request shape
  //////////////////////////////////////////////////////////////////////

  // The first burst starts at the aligned-down base, so count from there
  assign total_bytes = (BytesW'(len_i) << vew_i) + BytesW'(addr_i[BusBytesLog-1:0]);
  assign total_beats = CntW'((total_bytes + BytesW'(BusBytes - 1)) >> BusBytesLog);

  // Bytes left up to the end of the current 4 KiB page
  assign page_bytes = PageW'(1 << PageBits) - PageW'(cur_addr_q[PageBits-1:0]);
  assign page_beats = CntW'(page_bytes >> BusBytesLog);

  always_comb begin
    beats = CntW'(AxiMaxBurst);
    if (page_beats < beats) begin
      beats = page_beats;
    end
    if (cnt_q < beats) begin
      beats = cnt_q;
    end
    // Strided requests are single beats of element size
    if (!unit_stride_i) begin
      beats = CntW'(1);
    end
  end

  assign incr = unit_stride_i ? (axi_addr_t'(beats) << BusBytesLog) : stride_i;

  assign cur_addr_o = cur_addr_q;
  assign cur_len_o  = axi_len_t'(beats - CntW'(1));
  assign cur_size_o = unit_stride_i ? axi_size_t'(BusBytesLog) : axi_size_t'(vew_i);
  assign last_o     = (cnt_q == beats);

  //////////////////////////////////////////////////////////////////////
  // Running address and count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cur_addr_q <= '0;
      cnt_q      <= '0;
    end else if (start_i) begin
      if (unit_stride_i) begin
        cur_addr_q <= addr_i & ~axi_addr_t'(BusBytes - 1);
        cnt_q      <= total_beats;
      end else begin
        cur_addr_q <= addr_i;
        cnt_q      <= CntW'(len_i);
      end
    end else if (step_i) begin
      // A burst cut at the page end lands on the next page start
      cur_addr_q <= cur_addr_q + incr;
      cnt_q      <= cnt_q - beats;
    end
  end

endmodule

//--- hdl/axi_ax_issue.sv
/* Drives the planned requests onto AR or AW, keeps loads and stores from
   mixing in the load/store queue and pushes each transfer into it. */
`timescale 1ns/1ps

module axi_ax_issue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  logic                   is_load_i,
  // Request from the planner
  input  addrgen_pkg::axi_addr_t cur_addr_i,
  input  addrgen_pkg::axi_len_t  cur_len_i,
  input  addrgen_pkg::axi_size_t cur_size_i,
  input  logic                   last_i,
  // Load/store queue status
  input  logic                   q_empty_i,
  input  logic                   q_head_is_load_i,
  input  logic                   q_full_i,
  // AR channel
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output addrgen_pkg::axi_addr_t ar_addr_o,
  output addrgen_pkg::axi_len_t  ar_len_o,
  output addrgen_pkg::axi_size_t ar_size_o,
  // AW channel
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output addrgen_pkg::axi_addr_t aw_addr_o,
  output addrgen_pkg::axi_len_t  aw_len_o,
  output addrgen_pkg::axi_size_t aw_size_o,
  output logic                   push_o,
  output logic                   step_o,
  output logic                   done_o
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    SETTLE
  } state_e;

  state_e state_q, state_d;
  logic   may_issue;
  logic   ax_valid;
  logic   ax_ready;
  logic   fire;

  // The queue only ever holds one direction, its head tells which
  assign may_issue = !q_full_i && (q_empty_i || (q_head_is_load_i == is_load_i));
  assign ax_valid  = (state_q == REQ) && may_issue;
  assign ax_ready  = is_load_i ? ar_ready_i : aw_ready_i;
  assign fire      = ax_valid && ax_ready;

  assign ar_valid_o = ax_valid && is_load_i;
  assign ar_addr_o  = cur_addr_i;
  assign ar_len_o   = cur_len_i;
  assign ar_size_o  = cur_size_i;

  assign aw_valid_o = ax_valid && !is_load_i;
  assign aw_addr_o  = cur_addr_i;
  assign aw_len_o   = cur_len_i;
  assign aw_size_o  = cur_size_i;

  assign push_o = fire;
  assign step_o = fire;
  assign done_o = fire && last_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = REQ;
        end
      end
      REQ: begin
        if (fire) begin
          state_d = last_i ? IDLE : SETTLE;
        end
      end
      // Planner updates its outputs here
      SETTLE: state_d = REQ;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- hdl/lsu_req_fifo.sv
/* Circular queue of issued AXI requests, read by the load/store units
   in issue order. */
`timescale 1ns/1ps

module lsu_req_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  addrgen_pkg::axi_addr_t addr_i,
  input  addrgen_pkg::axi_len_t  len_i,
  input  addrgen_pkg::axi_size_t size_i,
  input  logic                   is_load_i,
  input  logic                   pop_i,
  output logic                   valid_o,
  output addrgen_pkg::axi_addr_t addr_o,
  output addrgen_pkg::axi_len_t  len_o,
  output addrgen_pkg::axi_size_t size_o,
  output logic                   is_load_o,
  output logic                   full_o,
  output logic                   empty_o
);

  import addrgen_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  typedef logic [PtrW-1:0] ptr_t;

  axi_addr_t       addr_mem    [Depth];
  axi_len_t        len_mem     [Depth];
  axi_size_t       size_mem    [Depth];
  logic            is_load_mem [Depth];
  ptr_t            wr_ptr_q;
  ptr_t            rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  // Pointers wrap at Depth, which need not be a power of two
  function automatic ptr_t ptr_next(ptr_t ptr);
    return (ptr == ptr_t'(Depth - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntW'(Depth));
  assign valid_o = !empty_o;
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign addr_o    = addr_mem[rd_ptr_q];
  assign len_o     = len_mem[rd_ptr_q];
  assign size_o    = size_mem[rd_ptr_q];
  assign is_load_o = is_load_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + CntW'(1);
      end else if (do_pop && !do_push) begin
        count_q <= count_q - CntW'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      addr_mem[wr_ptr_q]    <= addr_i;
      len_mem[wr_ptr_q]     <= len_i;
      size_mem[wr_ptr_q]    <= size_i;
      is_load_mem[wr_ptr_q] <= is_load_i;
    end
  end

endmodule

//--- hdl/vaddrgen_top.sv
/* Vector load/store address generator: turns one instruction at a time into
   AXI AR or AW requests and queues them for the load/store units. */
`timescale 1ns/1ps

module vaddrgen_top #(
  parameter int unsigned LsuQueueDepth = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Sequencer
  input  logic                   req_valid_i,
  input  logic                   req_is_load_i,
  input  logic                   req_unit_stride_i,
  input  addrgen_pkg::axi_addr_t req_addr_i,
  input  addrgen_pkg::vlen_t     req_len_i,
  input  addrgen_pkg::stride_t   req_stride_i,
  input  addrgen_pkg::vew_e      req_vew_i,
  output logic                   ack_o,
  output logic                   error_o,
  // AR channel
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output addrgen_pkg::axi_addr_t ar_addr_o,
  output addrgen_pkg::axi_len_t  ar_len_o,
  output addrgen_pkg::axi_size_t ar_size_o,
  // AW channel
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output addrgen_pkg::axi_addr_t aw_addr_o,
  output addrgen_pkg::axi_len_t  aw_len_o,
  output addrgen_pkg::axi_size_t aw_size_o,
  // Load/store unit queue
  output logic                   lsu_req_valid_o,
  output addrgen_pkg::axi_addr_t lsu_req_addr_o,
  output addrgen_pkg::axi_len_t  lsu_req_len_o,
  output addrgen_pkg::axi_size_t lsu_req_size_o,
  output logic                   lsu_req_is_load_o,
  input  logic                   lsu_req_pop_i
);

  import addrgen_pkg::*;

  // Held instruction
  logic      start;
  logic      is_load;
  logic      unit_stride;
  axi_addr_t addr;
  vlen_t     len;
  stride_t   stride;
  vew_e      vew;
  logic      done;

  // Current request from the planner
  axi_addr_t cur_addr;
  axi_len_t  cur_len;
  axi_size_t cur_size;
  logic      last;
  logic      step;

  // Queue handshake
  logic      push;
  logic      q_full;
  logic      q_empty;

  vmem_req_reg i_vmem_req_reg (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_valid_i      (req_valid_i),
    .req_is_load_i    (req_is_load_i),
    .req_unit_stride_i(req_unit_stride_i),
    .req_addr_i       (req_addr_i),
    .req_len_i        (req_len_i),
    .req_stride_i     (req_stride_i),
    .req_vew_i        (req_vew_i),
    .start_o          (start),
    .is_load_o        (is_load),
    .unit_stride_o    (unit_stride),
    .addr_o           (addr),
    .len_o            (len),
    .stride_o         (stride),
    .vew_o            (vew),
    .done_i           (done),
    .ack_o            (ack_o),
    .error_o          (error_o)
  );

  burst_planner i_burst_planner (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .unit_stride_i(unit_stride),
    .addr_i       (addr),
    .len_i        (len),
    .stride_i     (stride),
    .vew_i        (vew),
    .step_i       (step),
    .cur_addr_o   (cur_addr),
    .cur_len_o    (cur_len),
    .cur_size_o   (cur_size),
    .last_o       (last)
  );

  axi_ax_issue i_axi_ax_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .start_i         (start),
    .is_load_i       (is_load),
    .cur_addr_i      (cur_addr),
    .cur_len_i       (cur_len),
    .cur_size_i      (cur_size),
    .last_i          (last),
    .q_empty_i       (q_empty),
    .q_head_is_load_i(lsu_req_is_load_o),
    .q_full_i        (q_full),
    .ar_valid_o      (ar_valid_o),
    .ar_ready_i      (ar_ready_i),
    .ar_addr_o       (ar_addr_o),
    .ar_len_o        (ar_len_o),
    .ar_size_o       (ar_size_o),
    .aw_valid_o      (aw_valid_o),
    .aw_ready_i      (aw_ready_i),
    .aw_addr_o       (aw_addr_o),
    .aw_len_o        (aw_len_o),
    .aw_size_o       (aw_size_o),
    .push_o          (push),
    .step_o          (step),
    .done_o          (done)
  );

  lsu_req_fifo #(
    .Depth(LsuQueueDepth)
  ) i_lsu_req_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (push),
    .addr_i   (cur_addr),
    .len_i    (cur_len),
    .size_i   (cur_size),
    .is_load_i(is_load),
    .pop_i    (lsu_req_pop_i),
    .valid_o  (lsu_req_valid_o),
    .addr_o   (lsu_req_addr_o),
    .len_o    (lsu_req_len_o),
    .size_o   (lsu_req_size_o),
    .is_load_o(lsu_req_is_load_o),
    .full_o   (q_full),
    .empty_o  (q_empty)
  );

endmodule

//--- tb/vaddrgen_assert.sv
/* Bound checker of the address generator. It keeps a reference model of the AXI
   requests and of the load/store queue and compares them in concurrent assertions. */
`timescale 1ns/1ps

module vaddrgen_assert #(
  parameter int unsigned LsuQueueDepth = 4
) (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   req_valid_i,
  input logic                   req_is_load_i,
  input logic                   req_unit_stride_i,
  input addrgen_pkg::axi_addr_t req_addr_i,
  input addrgen_pkg::vlen_t     req_len_i,
  input addrgen_pkg::stride_t   req_stride_i,
  input addrgen_pkg::vew_e      req_vew_i,
  input logic                   ack_o,
  input logic                   error_o,
  input logic                   ar_valid_o,
  input logic                   ar_ready_i,
  input addrgen_pkg::axi_addr_t ar_addr_o,
  input addrgen_pkg::axi_len_t  ar_len_o,
  input addrgen_pkg::axi_size_t ar_size_o,
  input logic                   aw_valid_o,
  input logic                   aw_ready_i,
  input addrgen_pkg::axi_addr_t aw_addr_o,
  input addrgen_pkg::axi_len_t  aw_len_o,
  input addrgen_pkg::axi_size_t aw_size_o,
  input logic                   lsu_req_valid_o,
  input addrgen_pkg::axi_addr_t lsu_req_addr_o,
  input addrgen_pkg::axi_len_t  lsu_req_len_o,
  input addrgen_pkg::axi_size_t lsu_req_size_o,
  input logic                   lsu_req_is_load_o,
  input logic                   lsu_req_pop_i
);

  import addrgen_pkg::*;

  // Request as {is_load, addr, len, size}
  typedef logic [43:0] entry_t;

  int unsigned fail_cnt = 0;

  logic      m_busy;
  logic      m_err;
  logic      m_load;
  logic      m_unit;
  axi_addr_t m_addr;
  stride_t   m_stride;
  axi_size_t m_size;
  int        m_rem;
  entry_t    mq [64];
  int        wr_idx;
  int        rd_idx;
  int        q_cnt;
  int        page_left;
  int        beats;
  int        burst_end;
  logic      ar_fire;
  logic      aw_fire;
  logic      ax_fire;
  axi_addr_t ax_addr;
  axi_len_t  ax_len;
  axi_size_t ax_size;
  entry_t    exp_req;
  entry_t    act_req;
  entry_t    exp_head;
  entry_t    lsu_head;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  assign ar_fire = ar_valid_o && ar_ready_i;
  assign aw_fire = aw_valid_o && aw_ready_i;
  assign ax_fire = ar_fire || aw_fire;
  assign ax_addr = ar_valid_o ? ar_addr_o : aw_addr_o;
  assign ax_len  = ar_valid_o ? ar_len_o : aw_len_o;
  assign ax_size = ar_valid_o ? ar_size_o : aw_size_o;
  assign q_cnt   = wr_idx - rd_idx;

  always_comb begin
    // Beats left in the page of the running address
    page_left = ((1 << PageBits) - int'(m_addr[PageBits-1:0])) >> BusBytesLog;
    beats = 1;
    if (m_unit) begin
      beats = (m_rem < page_left) ? m_rem : page_left;
      if (beats > int'(AxiMaxBurst)) begin
        beats = int'(AxiMaxBurst);
      end
    end
    exp_req   = {m_load, m_addr, axi_len_t'(beats - 1),
                 m_unit ? axi_size_t'(BusBytesLog) : m_size};
    act_req   = {ar_fire, ax_addr, ax_len, ax_size};
    burst_end = int'(ax_addr[PageBits-1:0]) + ((int'(ax_len) + 1) << BusBytesLog);
    exp_head  = mq[rd_idx[5:0]];
    lsu_head  = {lsu_req_is_load_o, lsu_req_addr_o, lsu_req_len_o, lsu_req_size_o};
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_busy <= 1'b0;
      m_err  <= 1'b0;
      m_rem  <= 0;
      wr_idx <= 0;
      rd_idx <= 0;
    end else begin
      if (req_valid_i && !m_busy) begin
        m_busy   <= 1'b1;
        m_err    <= (int'(req_addr_i[2:0]) & ((1 << int'(req_vew_i)) - 1)) != 0;
        m_load   <= req_is_load_i;
        m_unit   <= req_unit_stride_i;
        m_stride <= req_stride_i;
        m_size   <= axi_size_t'(req_vew_i);
        if (req_unit_stride_i) begin
          // Whole beats from the aligned-down base to the last byte
          m_addr <= req_addr_i & ~axi_addr_t'((1 << BusBytesLog) - 1);
          m_rem  <= ((int'(req_len_i) << int'(req_vew_i)) + int'(req_addr_i[2:0])
                     + (1 << BusBytesLog) - 1) >> BusBytesLog;
        end else begin
          m_addr <= req_addr_i;
          m_rem  <= int'(req_len_i);
        end
      end else if (ack_o) begin
        m_busy <= 1'b0;
      end
      if (ax_fire) begin
        m_addr <= m_unit ? m_addr + (axi_addr_t'(beats) << BusBytesLog) : m_addr + m_stride;
        m_rem  <= m_rem - beats;
        mq[wr_idx[5:0]] <= exp_req;
        wr_idx <= wr_idx + 1;
      end
      if (lsu_req_valid_o && lsu_req_pop_i) begin
        rd_idx <= rd_idx + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_reset_idle: assert property (@(posedge clk_i)
    !rst_ni |-> !(ack_o || error_o || ar_valid_o || aw_valid_o || lsu_req_valid_o))
    else begin
      $error("Outputs are not idle while reset is held");
      fail_cnt++;
    end

  a_req_open: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ax_fire |-> m_busy && !m_err && m_rem > 0)
    else begin
      $error("AXI request issued with no accepted instruction left to serve");
      fail_cnt++;
    end

  a_req_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ax_fire |-> act_req == exp_req)
    else begin
      $error("Error ax_req: expected %h actual %h", exp_req, act_req);
      fail_cnt++;
    end

  a_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ax_fire && m_unit |-> burst_end <= (1 << PageBits))
    else begin
      $error("Burst at %h crosses a 4 KiB page", ax_addr);
      fail_cnt++;
    end

  a_ack_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |-> m_busy)
    else begin
      $error("Acknowledge with no open instruction");
      fail_cnt++;
    end

  a_ack_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o || error_o |-> ack_o && error_o == m_err)
    else begin
      $error("Error ack_error: expected %0d actual %0d", m_err, error_o);
      fail_cnt++;
    end

  a_ack_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o && !m_err |-> m_rem == 0)
    else begin
      $error("Error ack_remaining: expected 0 actual %0d", m_rem);
      fail_cnt++;
    end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ax_fire |-> q_cnt < int'(LsuQueueDepth))
    else begin
      $error("Request pushed into a full load/store queue");
      fail_cnt++;
    end

  a_lsu_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_valid_o == (q_cnt != 0))
    else begin
      $error("Error lsu_valid: expected %0d actual %0d", q_cnt != 0, lsu_req_valid_o);
      fail_cnt++;
    end

  a_lsu_head: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_valid_o |-> lsu_head == exp_head)
    else begin
      $error("Error lsu_head: expected %h actual %h", exp_head, lsu_head);
      fail_cnt++;
    end

  a_ar_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_fire |-> !lsu_req_valid_o || lsu_req_is_load_o)
    else begin
      $error("Load issued while a store heads the queue");
      fail_cnt++;
    end

  a_aw_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_fire |-> !lsu_req_valid_o || !lsu_req_is_load_o)
    else begin
      $error("Store issued while a load heads the queue");
      fail_cnt++;
    end

  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=>
      ar_valid_o && {ar_addr_o, ar_len_o, ar_size_o} == $past({ar_addr_o, ar_len_o, ar_size_o}))
    else begin
      $error("AR request dropped or changed while ready was low");
      fail_cnt++;
    end

  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=>
      aw_valid_o && {aw_addr_o, aw_len_o, aw_size_o} == $past({aw_addr_o, aw_len_o, aw_size_o}))
    else begin
      $error("AW request dropped or changed while ready was low");
      fail_cnt++;
    end

endmodule

//--- tb/tb_vaddrgen.sv
/* Testbench of the vector address generator. Random instructions under random AXI
   ready and queue pop; the bound checker compares every request and acknowledge. */
`timescale 1ns/1ps

module tb_vaddrgen;

  import addrgen_pkg::*;

  localparam int unsigned LsuQueueDepth  = 4;
  localparam int unsigned NumInstr       = 40;
  // Generous bound for one instruction under back-pressure
  localparam int unsigned CyclesPerInstr = 300;
  localparam int unsigned MaxCycles      = NumInstr * CyclesPerInstr;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_is_load;
  logic        req_unit_stride;
  axi_addr_t   req_addr;
  vlen_t       req_len;
  stride_t     req_stride;
  vew_e        req_vew;
  logic        ack;
  logic        error;
  logic        ar_valid;
  logic        ar_ready;
  axi_addr_t   ar_addr;
  axi_len_t    ar_len;
  axi_size_t   ar_size;
  logic        aw_valid;
  logic        aw_ready;
  axi_addr_t   aw_addr;
  axi_len_t    aw_len;
  axi_size_t   aw_size;
  logic        lsu_valid;
  axi_addr_t   lsu_addr;
  axi_len_t    lsu_len;
  axi_size_t   lsu_size;
  logic        lsu_is_load;
  logic        lsu_pop;
  logic [31:0] lfsr_q;
  int unsigned cycle_cnt;
  int unsigned done_cnt;
  int unsigned timeout_cnt;
  int unsigned fail_cnt;

  vaddrgen_top #(
    .LsuQueueDepth(LsuQueueDepth)
  ) i_vaddrgen_top (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .req_valid_i      (req_valid),
    .req_is_load_i    (req_is_load),
    .req_unit_stride_i(req_unit_stride),
    .req_addr_i       (req_addr),
    .req_len_i        (req_len),
    .req_stride_i     (req_stride),
    .req_vew_i        (req_vew),
    .ack_o            (ack),
    .error_o          (error),
    .ar_valid_o       (ar_valid),
    .ar_ready_i       (ar_ready),
    .ar_addr_o        (ar_addr),
    .ar_len_o         (ar_len),
    .ar_size_o        (ar_size),
    .aw_valid_o       (aw_valid),
    .aw_ready_i       (aw_ready),
    .aw_addr_o        (aw_addr),
    .aw_len_o         (aw_len),
    .aw_size_o        (aw_size),
    .lsu_req_valid_o  (lsu_valid),
    .lsu_req_addr_o   (lsu_addr),
    .lsu_req_len_o    (lsu_len),
    .lsu_req_size_o   (lsu_size),
    .lsu_req_is_load_o(lsu_is_load),
    .lsu_req_pop_i    (lsu_pop)
  );

  bind vaddrgen_top vaddrgen_assert #(
    .LsuQueueDepth(LsuQueueDepth)
  ) i_vaddrgen_assert (.*);

  //////////////////////////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = {value[30:0], lfsr_q[0]};
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Each ready is high three cycles out of four
  // The pop is high only one cycle in four so the queue fills up
  task automatic drive_handshake();
    logic [31:0] bits;
    draw_bits(6, bits);
    ar_ready = |bits[1:0];
    aw_ready = |bits[3:2];
    lsu_pop  = &bits[5:4];
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    cycle_cnt++;
    drive_handshake();
  endtask

  task automatic drive_instr();
    logic [31:0] bits;
    draw_bits(4, bits);
    req_is_load     = bits[0];
    req_unit_stride = bits[1];
    req_vew         = vew_e'(bits[3:2]);
    draw_bits(32, bits);
    req_addr = bits;
    draw_bits(2, bits);
    // About one base in five is off its element alignment
    if (bits[1:0] == 2'd0 && req_vew != EW8) begin
      // Random low bits, pushed off alignment if they happen to fit
      if ((req_addr & ((32'd1 << req_vew) - 32'd1)) == '0) begin
        req_addr[0] = 1'b1;
      end
    end else begin
      req_addr = req_addr & ~((32'd1 << req_vew) - 32'd1);
    end
    draw_bits(10, bits);
    if (req_unit_stride) begin
      req_len = vlen_t'(bits[9:0]) + vlen_t'(1);
    end else begin
      req_len = vlen_t'(bits[4:0]) + vlen_t'(1);
    end
    draw_bits(10, bits);
    req_stride = {{22{bits[9]}}, bits[9:0]};
    req_valid  = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] gap;
    lfsr_q          = 32'h8aa0_cc45;
    rst_n           = 1'b1;
    req_valid       = 1'b0;
    req_is_load     = 1'b0;
    req_unit_stride = 1'b0;
    req_addr        = '0;
    req_len         = '0;
    req_stride      = '0;
    req_vew         = EW8;
    ar_ready        = 1'b0;
    aw_ready        = 1'b0;
    lsu_pop         = 1'b0;
    cycle_cnt       = 0;
    done_cnt        = 0;
    timeout_cnt     = 0;
    #1;
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int n = 0; n < int'(NumInstr) && timeout_cnt == 0; n++) begin
      next_cycle();
      drive_instr();
      while (!ack && cycle_cnt < MaxCycles) begin
        next_cycle();
      end
      if (ack) begin
        done_cnt++;
      end else begin
        timeout_cnt++;
        $display("Timeout: instruction %0d got no acknowledge within %0d cycles", n, MaxCycles);
      end
      req_valid = 1'b0;
      draw_bits(2, gap);
      repeat (gap) next_cycle();
    end

    // Let the queue drain so its head checks run to the end
    repeat (20) next_cycle();

    fail_cnt = i_vaddrgen_top.i_vaddrgen_assert.fail_cnt;
    $display("Summary: %0d of %0d instructions acknowledged, %0d assertion failures, %0d timeouts",
             done_cnt, NumInstr, fail_cnt, timeout_cnt);
    if (fail_cnt == 0 && timeout_cnt == 0 && done_cnt == NumInstr) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
hdl/addrgen_pkg.sv
hdl/vmem_req_reg.sv
hdl/burst_planner.sv
hdl/axi_ax_issue.sv
hdl/lsu_req_fifo.sv
hdl/vaddrgen_top.sv
tb/vaddrgen_assert.sv
tb/tb_vaddrgen.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; passes only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_vaddrgen -f compile.f \
  && ./obj_dir/Vtb_vaddrgen +verilator+error+limit+1000000 \
     | tee /dev/stderr | grep -qx "TEST PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
